//--- common/mon_consts.svh
// Table depth and field widths for the AXI write monitor, included by the package and the RTL
`ifndef MON_CONSTS_SVH
`define MON_CONSTS_SVH

// ------------------------------
// Table sizing
// ------------------------------

// Outstanding write slots
`define MON_MAX_TRANS 8

// Active count width, must hold MON_MAX_TRANS
`define MON_CNT_W 4

// ------------------------------
// AXI field widths
// ------------------------------

// AWID and BID
`define MON_ID_W 4

// Write address
`define MON_ADDR_W 32

// AWLEN, so a burst has up to 256 beats
`define MON_LEN_W 8

`endif

//--- common/mon_pkg.sv
// Shared types of the AXI write monitor: state and event enums, channel and report structs
package mon_pkg;

    `include "mon_consts.svh"

    // Lifecycle of one table slot
    typedef enum logic [2:0] {
        TRANS_ADDR_PHASE,
        TRANS_DATA_PHASE,
        TRANS_COMPLETE,
        TRANS_ERROR,
        TRANS_ORPHANED
    } trans_state_t;

    // Event code carried in every report
    typedef enum logic [2:0] {
        EVT_NONE,
        EVT_RESP_SLVERR,
        EVT_RESP_DECERR,
        EVT_PROTOCOL,
        EVT_RESP_ORPHAN
    } evt_code_t;

    // Index of one table slot
    typedef logic [$clog2(`MON_MAX_TRANS)-1:0] slot_idx_t;

    // ------------------------------
    // Captured channel events
    // ------------------------------

    // AW handshake, exp_beats is AWLEN plus one
    typedef struct packed {
        logic                   valid;
        logic [`MON_ID_W-1:0]   id;
        logic [`MON_ADDR_W-1:0] addr;
        logic [`MON_LEN_W:0]    exp_beats;
    } cmd_evt_t;

    // W handshake
    typedef struct packed {
        logic valid;
        logic last;
    } beat_evt_t;

    // B handshake with decoded BRESP
    typedef struct packed {
        logic                 valid;
        logic [`MON_ID_W-1:0] id;
        logic                 err;
        evt_code_t            code;
    } resp_evt_t;

    // ------------------------------
    // Table row and report record
    // ------------------------------

    typedef struct packed {
        logic                   valid;
        trans_state_t           state;
        logic [`MON_ID_W-1:0]   id;
        logic [`MON_ADDR_W-1:0] addr;
        logic [`MON_LEN_W:0]    exp_beats;
        logic [`MON_LEN_W:0]    beat_cnt;
        logic                   data_completed;
        evt_code_t              code;
        logic                   reported;
    } trans_entry_t;

    // All slots side by side
    typedef trans_entry_t [`MON_MAX_TRANS-1:0] entry_tbl_t;

    typedef struct packed {
        logic [`MON_ID_W-1:0]   id;
        logic [`MON_ADDR_W-1:0] addr;
        logic [`MON_LEN_W:0]    beat_cnt;
        evt_code_t              code;
    } evt_rec_t;

endpackage

//--- design/wr_chan_capture.sv
// Samples the AW, W and B handshakes and registers each one as a one-cycle event strobe
`include "mon_consts.svh"

module wr_chan_capture (
    input  logic                   aclk,
    input  logic                   rst_n,
    // Write address channel
    input  logic                   aw_valid,
    input  logic                   aw_ready,
    input  logic [`MON_ID_W-1:0]   aw_id,
    input  logic [`MON_ADDR_W-1:0] aw_addr,
    input  logic [`MON_LEN_W-1:0]  aw_len,
    // Write data channel
    input  logic                   w_valid,
    input  logic                   w_ready,
    input  logic                   w_last,
    // Write response channel
    input  logic                   b_valid,
    input  logic                   b_ready,
    input  logic [`MON_ID_W-1:0]   b_id,
    input  logic [1:0]             b_resp,
    // Decoded events
    output mon_pkg::cmd_evt_t      cmd_evt,
    output mon_pkg::beat_evt_t     beat_evt,
    output mon_pkg::resp_evt_t     resp_evt
);
    import mon_pkg::*;

    // BRESP decode, bit 1 marks an error and bit 0 picks DECERR
    evt_code_t resp_code;

    always_comb begin
        if (!b_resp[1]) begin
            resp_code = EVT_NONE;
        end else if (b_resp[0]) begin
            resp_code = EVT_RESP_DECERR;
        end else begin
            resp_code = EVT_RESP_SLVERR;
        end
    end

    // ------------------------------
    // Handshake strobes
    // ------------------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            cmd_evt.valid  <= 1'b0;
            beat_evt.valid <= 1'b0;
            resp_evt.valid <= 1'b0;
        end else begin
            cmd_evt.valid  <= aw_valid && aw_ready;
            beat_evt.valid <= w_valid && w_ready;
            resp_evt.valid <= b_valid && b_ready;
        end
    end

    // ------------------------------
    // Payload, sampled every cycle
    // ------------------------------
    always_ff @(posedge aclk) begin
        cmd_evt.id        <= aw_id;
        cmd_evt.addr      <= aw_addr;
        // AWLEN counts beats minus one
        cmd_evt.exp_beats <= {1'b0, aw_len} + 1'b1;
        beat_evt.last     <= w_last;
        resp_evt.id       <= b_id;
        resp_evt.err      <= b_resp[1];
        resp_evt.code     <= resp_code;
    end

endmodule

//--- trans_table/wr_trans_table.sv
// Table of outstanding AXI writes: lookup by ID, state updates, active count and cleanup
`include "mon_consts.svh"

module wr_trans_table (
    input  logic                  aclk,
    input  logic                  rst_n,
    // Events from the channel capture
    input  mon_pkg::cmd_evt_t     cmd_evt,
    input  mon_pkg::beat_evt_t    beat_evt,
    input  mon_pkg::resp_evt_t    resp_evt,
    // Slot release from the reporter
    input  logic                  rep_done,
    input  mon_pkg::slot_idx_t    rep_idx,
    // Table view and occupancy
    output mon_pkg::entry_tbl_t   entries,
    output logic [`MON_CNT_W-1:0] active_count
);
    import mon_pkg::*;

    entry_tbl_t tbl;

    // Lookup results
    logic      cmd_hit;
    logic      free_found;
    slot_idx_t free_idx;
    logic      beat_found;
    slot_idx_t beat_idx;
    logic      resp_hit;
    slot_idx_t resp_idx;
    logic      orph_found;
    slot_idx_t orph_idx;

    // Slot creations this cycle
    logic cmd_new;
    logic orph_new;

    assign entries = tbl;

    // ------------------------------
    // Lookup
    // ------------------------------

    // Loops run downward so the lowest matching index is kept
    always_comb begin
        cmd_hit    = 1'b0;
        free_found = 1'b0;
        free_idx   = '0;
        beat_found = 1'b0;
        beat_idx   = '0;
        resp_hit   = 1'b0;
        resp_idx   = '0;
        for (int i = `MON_MAX_TRANS - 1; i >= 0; i--) begin
            // Any live entry with this ID blocks a new command
            if (tbl[i].valid && tbl[i].id == cmd_evt.id) begin
                cmd_hit = 1'b1;
            end
            if (!tbl[i].valid) begin
                free_found = 1'b1;
                free_idx   = slot_idx_t'(i);
            end
            // W carries no ID, so beats go to the oldest open burst
            if (tbl[i].valid && !tbl[i].data_completed &&
                (tbl[i].state == TRANS_ADDR_PHASE || tbl[i].state == TRANS_DATA_PHASE)) begin
                beat_found = 1'b1;
                beat_idx   = slot_idx_t'(i);
            end
            // Only entries still waiting for B can match a response
            if (tbl[i].valid && tbl[i].id == resp_evt.id &&
                (tbl[i].state == TRANS_ADDR_PHASE || tbl[i].state == TRANS_DATA_PHASE)) begin
                resp_hit = 1'b1;
                resp_idx = slot_idx_t'(i);
            end
        end
    end

    assign cmd_new = cmd_evt.valid && !cmd_hit && free_found;

    // Orphan takes the lowest free slot not claimed by a new command
    always_comb begin
        orph_found = 1'b0;
        orph_idx   = '0;
        for (int i = `MON_MAX_TRANS - 1; i >= 0; i--) begin
            if (!tbl[i].valid && !(cmd_new && slot_idx_t'(i) == free_idx)) begin
                orph_found = 1'b1;
                orph_idx   = slot_idx_t'(i);
            end
        end
    end

    assign orph_new = resp_evt.valid && !resp_hit && orph_found;

    // ------------------------------
    // Table update
    // ------------------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MON_MAX_TRANS; i++) begin
                tbl[i].valid <= 1'b0;
            end
            active_count <= '0;
        end else begin
            // New command in the address phase
            if (cmd_new) begin
                tbl[free_idx].valid          <= 1'b1;
                tbl[free_idx].state          <= TRANS_ADDR_PHASE;
                tbl[free_idx].id             <= cmd_evt.id;
                tbl[free_idx].addr           <= cmd_evt.addr;
                tbl[free_idx].exp_beats      <= cmd_evt.exp_beats;
                tbl[free_idx].beat_cnt       <= '0;
                tbl[free_idx].data_completed <= 1'b0;
                tbl[free_idx].code           <= EVT_NONE;
                tbl[free_idx].reported       <= 1'b0;
            end

            // Data beat, done at WLAST or at the expected count
            if (beat_evt.valid && beat_found) begin
                tbl[beat_idx].beat_cnt <= tbl[beat_idx].beat_cnt + 1'b1;
                tbl[beat_idx].state    <= TRANS_DATA_PHASE;
                if (beat_evt.last || tbl[beat_idx].beat_cnt + 1'b1 == tbl[beat_idx].exp_beats) begin
                    tbl[beat_idx].data_completed <= 1'b1;
                end
            end

            // Response, written after the beat so its state wins
            if (resp_evt.valid && resp_hit) begin
                if (resp_evt.err) begin
                    tbl[resp_idx].state <= TRANS_ERROR;
                    tbl[resp_idx].code  <= resp_evt.code;
                end else if (tbl[resp_idx].data_completed) begin
                    tbl[resp_idx].state <= TRANS_COMPLETE;
                end else begin
                    // B before the last W beat
                    tbl[resp_idx].state <= TRANS_ERROR;
                    tbl[resp_idx].code  <= EVT_PROTOCOL;
                end
            end

            // Response without a command
            if (orph_new) begin
                tbl[orph_idx].valid          <= 1'b1;
                tbl[orph_idx].state          <= TRANS_ORPHANED;
                tbl[orph_idx].id             <= resp_evt.id;
                tbl[orph_idx].addr           <= '0;
                tbl[orph_idx].exp_beats      <= '0;
                tbl[orph_idx].beat_cnt       <= '0;
                tbl[orph_idx].data_completed <= 1'b0;
                tbl[orph_idx].code           <= EVT_RESP_ORPHAN;
                tbl[orph_idx].reported       <= 1'b0;
            end

            // Release after the report is acknowledged
            if (rep_done) begin
                tbl[rep_idx].valid    <= 1'b0;
                tbl[rep_idx].reported <= 1'b1;
            end

            // Creations and release may coincide
            active_count <= active_count + `MON_CNT_W'(cmd_new) + `MON_CNT_W'(orph_new)
                            - `MON_CNT_W'(rep_done);
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    a_count_max: assert property (@(posedge aclk) disable iff (!rst_n)
        active_count <= `MON_MAX_TRANS);

    // Reporter only releases slots that hold a record
    a_done_valid: assert property (@(posedge aclk) disable iff (!rst_n)
        rep_done |-> tbl[rep_idx].valid);

endmodule

//--- design/event_reporter.sv
// Picks finished table entries and reports each one over a four-phase req/ack port
`include "mon_consts.svh"

module event_reporter (
    input  logic                aclk,
    input  logic                rst_n,
    // Table view
    input  mon_pkg::entry_tbl_t entries,
    // Event port
    input  logic                evt_ack,
    output logic                evt_req,
    output mon_pkg::evt_rec_t   evt_rec,
    // Slot release back to the table
    output logic                rep_done,
    output mon_pkg::slot_idx_t  rep_idx
);
    import mon_pkg::*;

    typedef enum logic [1:0] {
        REP_IDLE,
        REP_REQ,
        REP_WAIT_LOW
    } rep_state_t;

    rep_state_t state;

    // Lowest finished entry
    logic      pick_found;
    slot_idx_t pick_idx;

    // ------------------------------
    // Arbitration
    // ------------------------------
    always_comb begin
        pick_found = 1'b0;
        pick_idx   = '0;
        for (int i = `MON_MAX_TRANS - 1; i >= 0; i--) begin
            if (entries[i].valid && !entries[i].reported &&
                (entries[i].state == TRANS_COMPLETE || entries[i].state == TRANS_ERROR ||
                 entries[i].state == TRANS_ORPHANED)) begin
                pick_found = 1'b1;
                pick_idx   = slot_idx_t'(i);
            end
        end
    end

    // ------------------------------
    // Four-phase handshake FSM
    // ------------------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state    <= REP_IDLE;
            evt_req  <= 1'b0;
            rep_done <= 1'b0;
        end else begin
            rep_done <= 1'b0;
            case (state)
                REP_IDLE: begin
                    // Ack must be low before a new request
                    if (pick_found && !evt_ack) begin
                        evt_req <= 1'b1;
                        state   <= REP_REQ;
                    end
                end
                REP_REQ: begin
                    if (evt_ack) begin
                        evt_req  <= 1'b0;
                        rep_done <= 1'b1;
                        state    <= REP_WAIT_LOW;
                    end
                end
                REP_WAIT_LOW: begin
                    if (!evt_ack) begin
                        state <= REP_IDLE;
                    end
                end
                default: begin
                    state <= REP_IDLE;
                end
            endcase
        end
    end

    // Record and slot latched when the request goes up
    always_ff @(posedge aclk) begin
        if (state == REP_IDLE && pick_found && !evt_ack) begin
            evt_rec.id       <= entries[pick_idx].id;
            evt_rec.addr     <= entries[pick_idx].addr;
            evt_rec.beat_cnt <= entries[pick_idx].beat_cnt;
            evt_rec.code     <= entries[pick_idx].code;
            rep_idx          <= pick_idx;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    a_rec_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        evt_req |=> !evt_req || $stable(evt_rec));

    // Request only drops in answer to an ack
    a_req_held: assert property (@(posedge aclk) disable iff (!rst_n)
        $fell(evt_req) |-> $past(evt_ack));

endmodule

//--- design/axi_wr_monitor.sv
// Top of the passive AXI write monitor, connecting capture, transaction table and reporter
`include "mon_consts.svh"

module axi_wr_monitor (
    input  logic                   aclk,
    input  logic                   rst_n,
    // Observed AXI write channels
    input  logic                   aw_valid,
    input  logic                   aw_ready,
    input  logic [`MON_ID_W-1:0]   aw_id,
    input  logic [`MON_ADDR_W-1:0] aw_addr,
    input  logic [`MON_LEN_W-1:0]  aw_len,
    input  logic                   w_valid,
    input  logic                   w_ready,
    input  logic                   w_last,
    input  logic                   b_valid,
    input  logic                   b_ready,
    input  logic [`MON_ID_W-1:0]   b_id,
    input  logic [1:0]             b_resp,
    // Event port and occupancy
    input  logic                   evt_ack,
    output logic                   evt_req,
    output mon_pkg::evt_rec_t      evt_rec,
    output logic [`MON_CNT_W-1:0]  active_count
);
    import mon_pkg::*;

    // Capture to table
    cmd_evt_t   cmd_evt;
    beat_evt_t  beat_evt;
    resp_evt_t  resp_evt;
    // Table and reporter
    entry_tbl_t entries;
    logic       rep_done;
    slot_idx_t  rep_idx;

    wr_chan_capture u_capture (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_id    (aw_id),
        .aw_addr  (aw_addr),
        .aw_len   (aw_len),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_last   (w_last),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b_id     (b_id),
        .b_resp   (b_resp),
        .cmd_evt  (cmd_evt),
        .beat_evt (beat_evt),
        .resp_evt (resp_evt)
    );

    wr_trans_table u_table (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .cmd_evt      (cmd_evt),
        .beat_evt     (beat_evt),
        .resp_evt     (resp_evt),
        .rep_done     (rep_done),
        .rep_idx      (rep_idx),
        .entries      (entries),
        .active_count (active_count)
    );

    event_reporter u_reporter (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .entries  (entries),
        .evt_ack  (evt_ack),
        .evt_req  (evt_req),
        .evt_rec  (evt_rec),
        .rep_done (rep_done),
        .rep_idx  (rep_idx)
    );

endmodule

//--- dv/axi_wr_monitor_tb.sv
// Table-driven testbench for the AXI write monitor, built from files.f at the project root
`include "mon_consts.svh"

module axi_wr_monitor_tb;
    import mon_pkg::*;

    localparam int N_CASES = 7;
    // Each row gets 200 cycles
    localparam int TIMEOUT_CYCLES = 200 * N_CASES;

    // One row of stimulus and expected record
    typedef struct {
        string                name;
        bit                   send_cmd;
        bit [`MON_ID_W-1:0]   id;
        bit [`MON_LEN_W-1:0]  awlen;
        bit                   send_beats;
        bit [1:0]             bresp;
        evt_code_t            exp_code;
        int                   exp_beats;
    } test_case_t;

    logic                   aclk = 1'b0;
    logic                   rst_n;
    logic                   aw_valid;
    logic                   aw_ready;
    logic [`MON_ID_W-1:0]   aw_id;
    logic [`MON_ADDR_W-1:0] aw_addr;
    logic [`MON_LEN_W-1:0]  aw_len;
    logic                   w_valid;
    logic                   w_ready;
    logic                   w_last;
    logic                   b_valid;
    logic                   b_ready;
    logic [`MON_ID_W-1:0]   b_id;
    logic [1:0]             b_resp;
    logic                   evt_ack;
    logic                   evt_req;
    evt_rec_t               evt_rec;
    logic [`MON_CNT_W-1:0]  active_count;

    test_case_t cases [N_CASES];
    int         cycle_cnt = 0;

    axi_wr_monitor dut0 (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .aw_id        (aw_id),
        .aw_addr      (aw_addr),
        .aw_len       (aw_len),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .w_last       (w_last),
        .b_valid      (b_valid),
        .b_ready      (b_ready),
        .b_id         (b_id),
        .b_resp       (b_resp),
        .evt_ack      (evt_ack),
        .evt_req      (evt_req),
        .evt_rec      (evt_rec),
        .active_count (active_count)
    );

    always #10 aclk = ~aclk;

    // ------------------------------
    // Run limit
    // ------------------------------
    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the monitor gave no report within %0d cycles", cycle_cnt);
            $display("test failed");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_value(input string test, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s %s expected 0x%0h actual 0x%0h",
                     test, field, expected, actual);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge aclk);
    endtask

    // One AW handshake
    task automatic send_command(input logic [`MON_ID_W-1:0] id,
                                input logic [`MON_ADDR_W-1:0] addr,
                                input logic [`MON_LEN_W-1:0] len);
        @(posedge aclk);
        aw_valid <= 1'b1;
        aw_ready <= 1'b1;
        aw_id    <= id;
        aw_addr  <= addr;
        aw_len   <= len;
        @(posedge aclk);
        aw_valid <= 1'b0;
        aw_ready <= 1'b0;
    endtask

    // Back-to-back W beats, WLAST on the final one only when asked for
    task automatic send_beats(input int n, input bit mark_last);
        for (int b = 0; b < n; b++) begin
            @(posedge aclk);
            w_valid <= 1'b1;
            w_ready <= 1'b1;
            w_last  <= mark_last && (b == n - 1);
        end
        @(posedge aclk);
        w_valid <= 1'b0;
        w_ready <= 1'b0;
        w_last  <= 1'b0;
    endtask

    task automatic send_response(input logic [`MON_ID_W-1:0] id, input logic [1:0] resp);
        @(posedge aclk);
        b_valid <= 1'b1;
        b_ready <= 1'b1;
        b_id    <= id;
        b_resp  <= resp;
        @(posedge aclk);
        b_valid <= 1'b0;
        b_ready <= 1'b0;
    endtask

    task automatic wait_for_req();
        @(posedge aclk);
        while (!evt_req) @(posedge aclk);
    endtask

    // Remaining phases of the four-phase handshake
    task automatic acknowledge();
        @(posedge aclk);
        evt_ack <= 1'b1;
        @(posedge aclk);
        while (evt_req) @(posedge aclk);
        evt_ack <= 1'b0;
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        integer                 seed;
        logic [`MON_ADDR_W-1:0] addr;
        logic [`MON_ADDR_W-1:0] exp_addr;
        seed = 37;
        // name, cmd, id, awlen, beats, bresp, code, beats
        cases[0] = '{"single_okay", 1'b1, 4'h3, 8'd0, 1'b1, 2'b00, EVT_NONE, 1};
        cases[1] = '{"burst4_okay", 1'b1, 4'h5, 8'd3, 1'b1, 2'b00, EVT_NONE, 4};
        cases[2] = '{"early_wlast", 1'b1, 4'h6, 8'd3, 1'b1, 2'b00, EVT_NONE, 2};
        cases[3] = '{"slverr", 1'b1, 4'h1, 8'd1, 1'b1, 2'b10, EVT_RESP_SLVERR, 2};
        cases[4] = '{"decerr", 1'b1, 4'h2, 8'd0, 1'b1, 2'b11, EVT_RESP_DECERR, 1};
        cases[5] = '{"resp_no_data", 1'b1, 4'h7, 8'd1, 1'b0, 2'b00, EVT_PROTOCOL, 0};
        cases[6] = '{"orphan_resp", 1'b0, 4'h9, 8'd0, 1'b0, 2'b00, EVT_RESP_ORPHAN, 0};

        rst_n    <= 1'b0;
        aw_valid <= 1'b0;
        aw_ready <= 1'b0;
        aw_id    <= '0;
        aw_addr  <= '0;
        aw_len   <= '0;
        w_valid  <= 1'b0;
        w_ready  <= 1'b0;
        w_last   <= 1'b0;
        b_valid  <= 1'b0;
        b_ready  <= 1'b0;
        b_id     <= '0;
        b_resp   <= '0;
        evt_ack  <= 1'b0;
        repeat (5) @(posedge aclk);
        rst_n <= 1'b1;
        idle(2);

        for (int i = 0; i < N_CASES; i++) begin
            addr = $random(seed);
            if (cases[i].send_cmd) begin
                send_command(cases[i].id, addr, cases[i].awlen);
                idle(3);
            end
            // Gap lets the last beat settle before B is judged
            // A burst cut short ends on WLAST, a full burst ends on its beat count
            if (cases[i].send_beats) begin
                send_beats(cases[i].exp_beats, cases[i].exp_beats != cases[i].awlen + 1);
                idle(3);
            end
            send_response(cases[i].id, cases[i].bresp);
            wait_for_req();

            // An orphan has no address phase
            exp_addr = cases[i].send_cmd ? addr : '0;
            check_value(cases[i].name, "id", 64'(cases[i].id), 64'(evt_rec.id));
            check_value(cases[i].name, "addr", 64'(exp_addr), 64'(evt_rec.addr));
            check_value(cases[i].name, "beats", 64'(cases[i].exp_beats), 64'(evt_rec.beat_cnt));
            check_value(cases[i].name, "code", 64'(cases[i].exp_code), 64'(evt_rec.code));
            check_value(cases[i].name, "pending count", 64'd1, 64'(active_count));

            acknowledge();
            idle(4);
            check_value(cases[i].name, "idle count", 64'd0, 64'(active_count));
        end

        $display("test passed");
        $finish;
    end

endmodule

//--- files.f
+incdir+common
common/mon_pkg.sv
design/wr_chan_capture.sv
trans_table/wr_trans_table.sv
design/event_reporter.sv
design/axi_wr_monitor.sv
dv/axi_wr_monitor_tb.sv

//--- run.sh
#!/bin/bash
# Builds the monitor and its testbench with Verilator and runs the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module axi_wr_monitor_tb -o sim_axi_wr_monitor \
    && ./obj_dir/sim_axi_wr_monitor | tee /dev/stderr | grep -q "^test passed$" \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }
